//--- async_fifo.f
+incdir+verilog
verilog/async_fifo_pkg.sv
verilog/dualport_ram_async.sv
verilog/fifo_wr_ctrl.sv
verilog/fifo_rd_ctrl.sv
verilog/async_fifo.sv
tb/tb_clk_gen.sv
tb/tb_async_fifo.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the async FIFO testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

log="sim.log"
rm -f "$log"

verilator --binary --timing -Wno-fatal -f async_fifo.f \
  --top-module tb_async_fifo -o tb_async_fifo >"$log" 2>&1 &&
  ./obj_dir/tb_async_fifo >>"$log" 2>&1 ||
  { echo "build or run error"; echo "SIMULATION FAILED"; } >>"$log"

cat "$log"

# the testbench prints the fail line on any failed check or timeout.
grep -q "SIMULATION FAILED" "$log" && exit 1 || exit 0

//--- tb/tb_async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "async_fifo_macros.svh"

module tb_async_fifo
  import async_fifo_pkg::*;
();

  localparam int stream_words   = 200;
  localparam int crossing_slack = 5;        // reads not yet seen by the write side.
  localparam int wait_limit     = 64;
  localparam int stream_limit   = 4000;

  logic       wr_clk;
  logic       rd_clk;
  logic       wr_rst_n;
  logic       rd_rst_n;
  logic       wr_en;
  fifo_data_t wr_data;
  logic       rd_en;
  fifo_data_t rd_data;
  logic       full;
  logic       empty;
  logic       afull;
  logic       aempty;

  fifo_data_t ref_q [$];                    // accepted words, oldest first.
  fifo_data_t last_rd_word;
  int         data_errs;
  int         flag_errs;
  int         other_errs;

  tb_clk_gen #(.wr_period(8.0), .rd_period(11.0), .rst_cycles(5)) u_clk_gen (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .rd_rst_n (rd_rst_n)
  );

  async_fifo u_async_fifo (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .empty    (empty),
    .afull    (afull),
    .aempty   (aempty)
  );

  // --------------------------------------
  // compare and wait tasks
  // --------------------------------------
  task automatic check_data(input fifo_data_t exp, input fifo_data_t act);
    if (act !== exp) begin
      data_errs++;
      $display("Mismatch rd_data: expected 0x%0h, got 0x%0h at %0t", exp, act, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errs++;
      $display("Mismatch %s: expected 0x%0h, got 0x%0h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic wait_reset_done();
    int n;
    n = 0;
    while ((!wr_rst_n || !rd_rst_n) && n < wait_limit) begin
      @(negedge wr_clk);
      n++;
    end
    if (!wr_rst_n || !rd_rst_n) begin
      other_errs++;
      $display("timeout: reset was never released");
    end
  endtask

  task automatic wait_not_empty();
    int n;
    n = 0;
    while (empty && n < wait_limit) begin
      @(negedge rd_clk);
      n++;
    end
    if (empty) begin
      other_errs++;
      $display("timeout: empty stayed high for %0d rd_clk cycles", wait_limit);
    end
  endtask

  task automatic wait_not_full();
    int n;
    n = 0;
    while (full && n < wait_limit) begin
      @(negedge wr_clk);
      n++;
    end
    if (full) begin
      other_errs++;
      $display("timeout: full stayed high for %0d wr_clk cycles", wait_limit);
    end
  endtask

  // --------------------------------------
  // directed tests
  // --------------------------------------
  task automatic test_reset();
    @(negedge wr_clk);
    check_flag("full", 1'b0, full);
    check_flag("afull", 1'b0, afull);
    @(negedge rd_clk);
    check_flag("empty", 1'b1, empty);
    check_flag("aempty", 1'b1, aempty);
    check_data('0, rd_data);
  endtask

  task automatic test_fill_full();
    for (int i = 0; i <= `FIFO_DEPTH; i++) begin
      @(negedge wr_clk);
      check_flag("afull", i >= `FIFO_AFULL, afull);
      check_flag("full", i == `FIFO_DEPTH, full);
      wr_en   = 1'b1;                       // last pass writes into a full FIFO.
      wr_data = fifo_data_t'($urandom);
      if (i < `FIFO_DEPTH) begin
        ref_q.push_back(wr_data);
      end
    end
    @(negedge wr_clk);
    wr_en = 1'b0;
    check_flag("full", 1'b1, full);
  endtask

  task automatic test_drain_order();
    fifo_data_t exp;
    int         n;
    n = 0;
    wait_not_empty();
    while (ref_q.size() > 0 && n < stream_limit) begin
      @(negedge rd_clk);
      n++;
      if (!empty) begin
        rd_en = 1'b1;
        exp   = ref_q.pop_front();
        @(negedge rd_clk);
        rd_en = 1'b0;
        check_data(exp, rd_data);
        check_flag("aempty", ref_q.size() <= `FIFO_AEMPTY, aempty);
        last_rd_word = exp;
      end
    end
    if (ref_q.size() != 0) begin
      other_errs++;
      $display("timeout: drain stopped with %0d words left", ref_q.size());
    end
    check_flag("empty", 1'b1, empty);
    check_flag("aempty", 1'b1, aempty);
    wait_not_full();
  endtask

  task automatic test_underflow();
    @(negedge rd_clk);
    check_flag("empty", 1'b1, empty);
    rd_en = 1'b1;
    @(negedge rd_clk);
    rd_en = 1'b0;
    check_data(last_rd_word, rd_data);
    check_flag("empty", 1'b1, empty);
  endtask

  task automatic stream_writer();
    int n_wr;
    int n;
    n_wr = 0;
    n    = 0;
    while (n_wr < stream_words && n < stream_limit) begin
      @(negedge wr_clk);
      n++;
      if (full && ref_q.size() < `FIFO_DEPTH - crossing_slack) begin
        flag_errs++;
        $display("full high with only %0d words queued at %0t", ref_q.size(), $time);
      end
      if (!full && ref_q.size() >= `FIFO_DEPTH) begin
        flag_errs++;
        $display("full low with %0d words queued at %0t", ref_q.size(), $time);
      end
      wr_en   = ($urandom_range(0, 99) < 75);
      wr_data = fifo_data_t'($urandom);
      if (wr_en && !full) begin
        ref_q.push_back(wr_data);
        n_wr++;
      end
    end
    @(negedge wr_clk);
    wr_en = 1'b0;
    if (n_wr < stream_words) begin
      other_errs++;
      $display("timeout: only %0d of %0d stream writes accepted", n_wr, stream_words);
    end
  endtask

  task automatic stream_reader();
    fifo_data_t exp;
    logic       pending;
    int         n_rd;
    int         n;
    pending = 1'b0;
    n_rd    = 0;
    n       = 0;
    exp     = '0;
    while (n_rd < stream_words && n < stream_limit) begin
      @(negedge rd_clk);
      n++;
      if (pending) begin
        check_data(exp, rd_data);
        pending = 1'b0;
      end
      rd_en = ($urandom_range(0, 99) < 60);
      if (rd_en && !empty) begin
        if (ref_q.size() == 0) begin
          other_errs++;
          $display("read accepted with nothing written at %0t", $time);
        end else begin
          exp     = ref_q.pop_front();
          pending = 1'b1;
          n_rd++;
        end
      end
    end
    @(negedge rd_clk);
    rd_en = 1'b0;
    if (pending) begin
      check_data(exp, rd_data);
    end
    if (n_rd < stream_words) begin
      other_errs++;
      $display("timeout: only %0d of %0d stream reads accepted", n_rd, stream_words);
    end
  endtask

  task automatic test_stream();
    fork
      stream_writer();
      stream_reader();
    join
    check_flag("empty", 1'b1, empty);
    if (ref_q.size() != 0) begin
      other_errs++;
      $display("%0d stream words never came out", ref_q.size());
    end
  endtask

  // --------------------------------------
  // main sequence
  // --------------------------------------
  initial begin
    wr_en        = 1'b0;
    wr_data      = '0;
    rd_en        = 1'b0;
    last_rd_word = '0;
    data_errs    = 0;
    flag_errs    = 0;
    other_errs   = 0;
    void'($urandom(76));

    wait_reset_done();
    test_reset();
    test_fill_full();
    test_drain_order();
    test_underflow();
    test_stream();

    $display("errors: data %0d, flag %0d, other %0d", data_errs, flag_errs, other_errs);
    if (data_errs + flag_errs + other_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real wr_period  = 8.0,
  parameter real rd_period  = 11.0,
  parameter int  rst_cycles = 5
) (
  output logic wr_clk,
  output logic rd_clk,
  output logic wr_rst_n,
  output logic rd_rst_n
);

  initial begin
    wr_clk = 1'b0;
    forever #(wr_period / 2.0) wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #(rd_period / 2.0) rd_clk = ~rd_clk;
  end

  // both domains leave reset on a falling wr_clk edge.
  initial begin
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    repeat (rst_cycles) @(posedge wr_clk);
    @(negedge wr_clk);
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- verilog/async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo
  import async_fifo_pkg::*;
(
  input  logic       wr_clk,
  input  logic       wr_rst_n,
  input  logic       wr_en,
  input  fifo_data_t wr_data,
  input  logic       rd_clk,
  input  logic       rd_rst_n,
  input  logic       rd_en,
  output fifo_data_t rd_data,
  output logic       full,
  output logic       empty,
  output logic       afull,
  output logic       aempty
);

  // --------------------------------------
  // internal wires
  // --------------------------------------
  logic       ram_wr_en;
  fifo_addr_t ram_wr_addr;
  logic       ram_rd_en;
  fifo_addr_t ram_rd_addr;

  fifo_ptr_t  wr_ptr_gray;                  // wr_clk domain, into read side.
  fifo_ptr_t  rd_ptr_gray;                  // rd_clk domain, into write side.

  // --------------------------------------
  // write domain
  // --------------------------------------
  fifo_wr_ctrl u_wr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_ptr_gray (rd_ptr_gray),
    .ram_wr_en   (ram_wr_en),
    .ram_wr_addr (ram_wr_addr),
    .wr_ptr_gray (wr_ptr_gray),
    .full        (full),
    .afull       (afull)
  );

  // --------------------------------------
  // read domain
  // --------------------------------------
  fifo_rd_ctrl u_rd_ctrl (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_gray (wr_ptr_gray),
    .ram_rd_en   (ram_rd_en),
    .ram_rd_addr (ram_rd_addr),
    .rd_ptr_gray (rd_ptr_gray),
    .empty       (empty),
    .aempty      (aempty)
  );

  // storage spans both domains.
  dualport_ram_async u_ram (
    .wr_clk   (wr_clk),
    .wr_en    (ram_wr_en),
    .wr_addr  (ram_wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (ram_rd_en),
    .rd_addr  (ram_rd_addr),
    .rd_data  (rd_data)
  );

endmodule

`default_nettype wire

//--- verilog/async_fifo_macros.svh
`ifndef ASYNC_FIFO_MACROS_SVH
`define ASYNC_FIFO_MACROS_SVH

// --------------------------------------
// data path size
// --------------------------------------
`define FIFO_DATA_WIDTH 8                       // bits per word.

// depth must stay a power of two.
`define FIFO_DEPTH      16
`define FIFO_ADDR_WIDTH 4                       // log2 of FIFO_DEPTH.

// --------------------------------------
// flag thresholds, in entries
// --------------------------------------
`define FIFO_AFULL      (`FIFO_DEPTH - 2)       // afull at or above this fill.
`define FIFO_AEMPTY     2                       // aempty at or below this fill.

`endif

//--- verilog/async_fifo_pkg.sv
`default_nettype none

`include "async_fifo_macros.svh"

package async_fifo_pkg;

  typedef logic [`FIFO_DATA_WIDTH-1:0] fifo_data_t;
  typedef logic [`FIFO_ADDR_WIDTH-1:0] fifo_addr_t;
  typedef logic [`FIFO_ADDR_WIDTH:0]   fifo_ptr_t;   // address plus wrap bit.

  // --------------------------------------
  // gray code helpers
  // --------------------------------------
  function automatic fifo_ptr_t bin_to_gray(input fifo_ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic fifo_ptr_t gray_to_bin(input fifo_ptr_t gray);
    fifo_ptr_t bin;
    bin[`FIFO_ADDR_WIDTH] = gray[`FIFO_ADDR_WIDTH];
    for (int i = `FIFO_ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];          // fold from the msb down.
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

//--- verilog/dualport_ram_async.sv
`timescale 1ns/1ps
`default_nettype none

`include "async_fifo_macros.svh"

module dualport_ram_async
  import async_fifo_pkg::*;
(
  input  logic       wr_clk,
  input  logic       wr_en,
  input  fifo_addr_t wr_addr,
  input  fifo_data_t wr_data,
  input  logic       rd_clk,
  input  logic       rd_rst_n,
  input  logic       rd_en,
  input  fifo_addr_t rd_addr,
  output fifo_data_t rd_data
);

  fifo_data_t mem [`FIFO_DEPTH];

  // --------------------------------------
  // write port
  // --------------------------------------
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // --------------------------------------
  // read port
  // --------------------------------------
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];              // holds until the next accepted read.
    end
  end

endmodule

`default_nettype wire

//--- verilog/fifo_rd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "async_fifo_macros.svh"

module fifo_rd_ctrl
  import async_fifo_pkg::*;
(
  input  logic       rd_clk,
  input  logic       rd_rst_n,
  input  logic       rd_en,
  input  fifo_ptr_t  wr_ptr_gray,
  output logic       ram_rd_en,
  output fifo_addr_t ram_rd_addr,
  output fifo_ptr_t  rd_ptr_gray,
  output logic       empty,
  output logic       aempty
);

  logic      rd_vld;
  fifo_ptr_t rd_ptr_bin;
  fifo_ptr_t rd_ptr_bin_nxt;
  fifo_ptr_t rd_ptr_gray_nxt;

  fifo_ptr_t wr_gray_sync1;
  fifo_ptr_t wr_gray_sync2;
  fifo_ptr_t wr_ptr_bin_sync;

  fifo_ptr_t rd_fill;
  logic      empty_nxt;
  logic      aempty_nxt;

  // --------------------------------------
  // read pointer
  // --------------------------------------
  assign rd_vld      = rd_en & ~empty;      // reads while empty are ignored.
  assign ram_rd_en   = rd_vld;
  assign ram_rd_addr = rd_ptr_bin[`FIFO_ADDR_WIDTH-1:0];

  always_comb begin
    rd_ptr_bin_nxt = rd_ptr_bin;
    if (rd_vld) begin
      rd_ptr_bin_nxt = rd_ptr_bin + 1'b1;
    end
  end

  assign rd_ptr_gray_nxt = bin_to_gray(rd_ptr_bin_nxt);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr_bin  <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr_bin  <= rd_ptr_bin_nxt;
      rd_ptr_gray <= rd_ptr_gray_nxt;
    end
  end

  // --------------------------------------
  // write pointer crossing
  // --------------------------------------
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_gray_sync1 <= '0;
      wr_gray_sync2 <= '0;
    end else begin
      wr_gray_sync1 <= wr_ptr_gray;
      wr_gray_sync2 <= wr_gray_sync1;
    end
  end

  assign wr_ptr_bin_sync = gray_to_bin(wr_gray_sync2);

  // --------------------------------------
  // flags
  // --------------------------------------
  // equal pointers, wrap bit included, mean nothing is left to read.
  assign empty_nxt = (rd_ptr_gray_nxt == wr_gray_sync2);

  assign rd_fill    = wr_ptr_bin_sync - rd_ptr_bin_nxt;  // lags real writes.
  assign aempty_nxt = (rd_fill <= fifo_ptr_t'(`FIFO_AEMPTY));

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_nxt;
      aempty <= aempty_nxt;
    end
  end

endmodule

`default_nettype wire

//--- verilog/fifo_wr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "async_fifo_macros.svh"

module fifo_wr_ctrl
  import async_fifo_pkg::*;
(
  input  logic       wr_clk,
  input  logic       wr_rst_n,
  input  logic       wr_en,
  input  fifo_ptr_t  rd_ptr_gray,
  output logic       ram_wr_en,
  output fifo_addr_t ram_wr_addr,
  output fifo_ptr_t  wr_ptr_gray,
  output logic       full,
  output logic       afull
);

  logic      wr_vld;
  fifo_ptr_t wr_ptr_bin;
  fifo_ptr_t wr_ptr_bin_nxt;
  fifo_ptr_t wr_ptr_gray_nxt;

  fifo_ptr_t rd_gray_sync1;
  fifo_ptr_t rd_gray_sync2;
  fifo_ptr_t rd_ptr_bin_sync;

  fifo_ptr_t wr_used;
  fifo_ptr_t full_gray;
  logic      full_nxt;
  logic      afull_nxt;

  // --------------------------------------
  // write pointer
  // --------------------------------------
  assign wr_vld      = wr_en & ~full;       // writes while full are dropped.
  assign ram_wr_en   = wr_vld;
  assign ram_wr_addr = wr_ptr_bin[`FIFO_ADDR_WIDTH-1:0];

  always_comb begin
    wr_ptr_bin_nxt = wr_ptr_bin;
    if (wr_vld) begin
      wr_ptr_bin_nxt = wr_ptr_bin + 1'b1;
    end
  end

  assign wr_ptr_gray_nxt = bin_to_gray(wr_ptr_bin_nxt);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr_bin  <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr_bin  <= wr_ptr_bin_nxt;
      wr_ptr_gray <= wr_ptr_gray_nxt;   // only one bit changes per edge.
    end
  end

  // --------------------------------------
  // read pointer crossing
  // --------------------------------------
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_sync1 <= '0;
      rd_gray_sync2 <= '0;
    end else begin
      rd_gray_sync1 <= rd_ptr_gray;
      rd_gray_sync2 <= rd_gray_sync1;
    end
  end

  assign rd_ptr_bin_sync = gray_to_bin(rd_gray_sync2);

  // --------------------------------------
  // flags
  // --------------------------------------
  // full when the write pointer is one lap ahead of the read pointer.
  assign full_gray = {~rd_gray_sync2[`FIFO_ADDR_WIDTH:`FIFO_ADDR_WIDTH-1],
                      rd_gray_sync2[`FIFO_ADDR_WIDTH-2:0]};
  assign full_nxt  = (wr_ptr_gray_nxt == full_gray);

  assign wr_used   = wr_ptr_bin_nxt - rd_ptr_bin_sync;  // stale read side, so never low.
  assign afull_nxt = (wr_used >= fifo_ptr_t'(`FIFO_AFULL));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_nxt;
      afull <= afull_nxt;
    end
  end

endmodule

`default_nettype wire
